// ==== arcade_pkg.sv ====
package arcade_pkg;

	// ============================================================
	// Clock enable ratios
	// ============================================================

	// clk_sys cycles per 6 MHz pixel enable
	localparam int CE_PIX_DIV = 4;
	// clk_sys cycles per 1.79 MHz sound enable
	localparam int CE_SND_DIV = 13;

	localparam int CE_PIX_W = $clog2(CE_PIX_DIV);
	localparam int CE_SND_W = $clog2(CE_SND_DIV);

	// Terminal counts where each divider wraps and fires its pulse
	localparam logic [CE_PIX_W-1:0] CE_PIX_LAST = CE_PIX_W'(CE_PIX_DIV - 1);
	localparam logic [CE_SND_W-1:0] CE_SND_LAST = CE_SND_W'(CE_SND_DIV - 1);

	// ============================================================
	// Audio
	// ============================================================

	localparam int AUDIO_W = 10;

	// ============================================================
	// Player input bit positions
	// ============================================================

	// Bit positions in the joystick byte of each physical stick
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// Bit positions in the 10-bit decoded keyboard vector
	localparam int KB_FIRE   = 0;
	localparam int KB_START1 = 1;
	localparam int KB_START2 = 2;
	localparam int KB_COIN   = 3;
	localparam int KB_RIGHT  = 4;
	localparam int KB_LEFT   = 5;
	localparam int KB_DOWN   = 6;
	localparam int KB_UP     = 7;

	// ============================================================
	// Video
	// ============================================================

	// Scanline effect applied to odd lines
	typedef enum logic [1:0] {
		SCAN_NONE  = 2'd0,
		SCAN_DIM25 = 2'd1,
		SCAN_DIM50 = 2'd2
	} scan_mode_e;

endpackage

// ==== clock_enables.sv ====
module clock_enables (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_pix,
	output logic ce_snd
);

	logic [arcade_pkg::CE_PIX_W-1:0] pix_cnt;
	logic [arcade_pkg::CE_SND_W-1:0] snd_cnt;

	// The pixel enable pulses once per CE_PIX_DIV cycles
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pix_cnt <= '0;
			ce_pix  <= 1'b0;
		end else if (pix_cnt == arcade_pkg::CE_PIX_LAST) begin
			pix_cnt <= '0;
			ce_pix  <= 1'b1;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
			ce_pix  <= 1'b0;
		end
	end

	// The sound enable pulses once per CE_SND_DIV cycles
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			snd_cnt <= '0;
			ce_snd  <= 1'b0;
		end else if (snd_cnt == arcade_pkg::CE_SND_LAST) begin
			snd_cnt <= '0;
			ce_snd  <= 1'b1;
		end else begin
			snd_cnt <= snd_cnt + 1'b1;
			ce_snd  <= 1'b0;
		end
	end

	// The core counts on these as single-cycle strobes
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |=> !ce_pix)
		else $error("ce_pix high on two consecutive cycles");

	assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_snd |=> !ce_snd)
		else $error("ce_snd high on two consecutive cycles");

endmodule

// ==== control_mapper.sv ====
module control_mapper (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [9:0] kb_joy,
	input  logic [7:0] joy0,
	input  logic [7:0] joy1,
	input  logic       upright,
	output logic [7:0] in0,
	output logic [7:0] in1
);

	// ============================================================
	// Input synchronizers
	// ============================================================

	logic [9:0] kb_meta, kb_sync;
	logic [7:0] j0_meta, j0_sync;
	logic [7:0] j1_meta, j1_sync;
	logic       up_meta, up_sync;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			kb_meta <= '0;
			kb_sync <= '0;
			j0_meta <= '0;
			j0_sync <= '0;
			j1_meta <= '0;
			j1_sync <= '0;
			up_meta <= 1'b0;
			up_sync <= 1'b0;
		end else begin
			kb_meta <= kb_joy;
			kb_sync <= kb_meta;
			j0_meta <= joy0;
			j0_sync <= j0_meta;
			j1_meta <= joy1;
			j1_sync <= j1_meta;
			up_meta <= upright;
			up_sync <= up_meta;
		end
	end

	// ============================================================
	// Source merge and orientation
	// ============================================================

	logic src_up, src_down, src_left, src_right;
	logic m_up, m_down, m_left, m_right;
	logic m_fire;

	// Any of the two sticks or the keyboard can drive a direction
	assign src_up    = kb_sync[arcade_pkg::KB_UP] | j0_sync[arcade_pkg::JOY_UP] |
	                   j1_sync[arcade_pkg::JOY_UP];
	assign src_down  = kb_sync[arcade_pkg::KB_DOWN] | j0_sync[arcade_pkg::JOY_DOWN] |
	                   j1_sync[arcade_pkg::JOY_DOWN];
	assign src_left  = kb_sync[arcade_pkg::KB_LEFT] | j0_sync[arcade_pkg::JOY_LEFT] |
	                   j1_sync[arcade_pkg::JOY_LEFT];
	assign src_right = kb_sync[arcade_pkg::KB_RIGHT] | j0_sync[arcade_pkg::JOY_RIGHT] |
	                   j1_sync[arcade_pkg::JOY_RIGHT];
	assign m_fire    = kb_sync[arcade_pkg::KB_FIRE] | j0_sync[arcade_pkg::JOY_FIRE] |
	                   j1_sync[arcade_pkg::JOY_FIRE];

	// Upright cabinet turns the stick a quarter to match the rotated monitor
	assign m_up    = up_sync ? src_left  : src_up;
	assign m_down  = up_sync ? src_right : src_down;
	assign m_left  = up_sync ? src_down  : src_left;
	assign m_right = up_sync ? src_up    : src_right;

	// Core bytes are active low, so all ones means nothing pressed
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			in0 <= 8'hff;
			in1 <= 8'hff;
		end else begin
			in0 <= ~{2'b00, kb_sync[arcade_pkg::KB_COIN], m_fire,
			         m_down, m_right, m_left, m_up};
			in1 <= ~{1'b0, kb_sync[arcade_pkg::KB_START2],
			         kb_sync[arcade_pkg::KB_START1], 5'b00000};
		end
	end

	// The remap only permutes directions, so no press is lost or doubled
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		$countones(~in0[3:0]) ==
		$countones($past({src_up, src_down, src_left, src_right})))
		else $error("in0 direction count differs from the sources: %h", in0);

endmodule

// ==== video_out.sv ====
module video_out (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   ce_pix,
	input  logic [2:0]             core_r,
	input  logic [2:0]             core_g,
	input  logic [1:0]             core_b,
	input  logic                   core_hs,
	input  logic                   core_vs,
	input  logic                   core_hblank,
	input  logic                   core_vblank,
	input  arcade_pkg::scan_mode_e scan_mode,
	output logic [5:0]             vga_r,
	output logic [5:0]             vga_g,
	output logic [5:0]             vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs
);

	// ============================================================
	// Line parity
	// ============================================================

	logic hs_prev;
	logic line_odd;

	// Parity restarts each frame and flips on every hsync rising edge
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_prev  <= 1'b0;
			line_odd <= 1'b0;
		end else if (ce_pix) begin
			hs_prev <= core_hs;
			if (core_vs) begin
				line_odd <= 1'b0;
			end else if (core_hs && !hs_prev) begin
				line_odd <= ~line_odd;
			end
		end
	end

	// ============================================================
	// Colour expansion and scanlines
	// ============================================================

	// Dims a 6-bit level on odd lines
	function automatic logic [5:0] dim_level(
		input logic [5:0]             level,
		input arcade_pkg::scan_mode_e mode,
		input logic                   odd
	);
		logic [5:0] result;
		result = level;
		if (odd) begin
			case (mode)
				arcade_pkg::SCAN_DIM25: result = level - (level >> 2);
				arcade_pkg::SCAN_DIM50: result = level >> 1;
				default:                result = level;
			endcase
		end
		return result;
	endfunction

	logic [5:0] exp_r, exp_g, exp_b;
	logic [5:0] out_r, out_g, out_b;
	logic       blank;

	// Bit replication keeps full white at 6'h3f
	assign exp_r = {core_r, core_r};
	assign exp_g = {core_g, core_g};
	assign exp_b = {core_b, core_b, core_b};
	assign blank = core_hblank | core_vblank;

	always_comb begin
		if (blank) begin
			out_r = '0;
			out_g = '0;
			out_b = '0;
		end else begin
			out_r = dim_level(exp_r, scan_mode, line_odd);
			out_g = dim_level(exp_g, scan_mode, line_odd);
			out_b = dim_level(exp_b, scan_mode, line_odd);
		end
	end

	// Colour and syncs move together so the picture stays aligned
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (ce_pix) begin
			vga_r  <= out_r;
			vga_g  <= out_g;
			vga_b  <= out_b;
			vga_hs <= core_hs;
			vga_vs <= core_vs;
		end
	end

	// Blanking seen on a pixel enable must give black on the next pixel
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ce_pix && (core_hblank || core_vblank)) |=>
		(vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("colour not black after blanking: %h %h %h", vga_r, vga_g, vga_b);

endmodule

// ==== sigma_delta_dac.sv ====
module sigma_delta_dac (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  logic [arcade_pkg::AUDIO_W-1:0] sample,
	output logic                           bit_out
);

	// ============================================================
	// First-order modulator
	// ============================================================

	logic [arcade_pkg::AUDIO_W-1:0] acc;
	logic [arcade_pkg::AUDIO_W:0]   sum;

	// The carry out of the accumulator is the output bit, and the
	// remainder is the error fed back into the next cycle
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc     <= '0;
			bit_out <= 1'b0;
		end else begin
			acc     <= sum[arcade_pkg::AUDIO_W-1:0];
			bit_out <= sum[arcade_pkg::AUDIO_W];
		end
	end

	// Over one full accumulator period the pulse count equals the
	// sample value, so an external RC filter recovers the level

endmodule

// ==== arcade_shell.sv ====
module arcade_shell (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	// Player controls
	input  logic [9:0]                     kb_joy,
	input  logic [7:0]                     joy0,
	input  logic [7:0]                     joy1,
	input  logic                           upright,
	input  logic [1:0]                     scan_mode,
	// Game core video and audio
	input  logic [2:0]                     core_r,
	input  logic [2:0]                     core_g,
	input  logic [1:0]                     core_b,
	input  logic                           core_hs,
	input  logic                           core_vs,
	input  logic                           core_hblank,
	input  logic                           core_vblank,
	input  logic [arcade_pkg::AUDIO_W-1:0] core_audio,
	// Enables and input bytes for the game core
	output logic                           ce_pix,
	output logic                           ce_snd,
	output logic [7:0]                     in0,
	output logic [7:0]                     in1,
	// Board pins
	output logic [5:0]                     vga_r,
	output logic [5:0]                     vga_g,
	output logic [5:0]                     vga_b,
	output logic                           vga_hs,
	output logic                           vga_vs,
	output logic                           audio_l,
	output logic                           audio_r
);

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_pix  (ce_pix),
		.ce_snd  (ce_snd)
	);

	control_mapper u_control_mapper (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.kb_joy  (kb_joy),
		.joy0    (joy0),
		.joy1    (joy1),
		.upright (upright),
		.in0     (in0),
		.in1     (in1)
	);

	video_out u_video_out (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.ce_pix      (ce_pix),
		.core_r      (core_r),
		.core_g      (core_g),
		.core_b      (core_b),
		.core_hs     (core_hs),
		.core_vs     (core_vs),
		.core_hblank (core_hblank),
		.core_vblank (core_vblank),
		.scan_mode   (arcade_pkg::scan_mode_e'(scan_mode)),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (core_audio),
		.bit_out (audio_l)
	);

	// The mono stream drives both audio channels
	assign audio_r = audio_l;

endmodule

// ==== tb_arcade_shell.sv ====
module tb_arcade_shell;

	timeunit 1ns;
	timeprecision 1ps;

	// Phase lengths in clk_sys cycles that size the timeout
	localparam int IDLE_CYCLES    = 40;
	localparam int MAP_SETTINGS   = 200;
	localparam int MAP_CYCLES     = MAP_SETTINGS * 8;
	localparam int COLOUR_CYCLES  = 400;
	localparam int FRAMES         = 2;
	localparam int LINES          = 5;
	localparam int PIXELS         = 12;
	localparam int RASTER_CYCLES  = 2 * FRAMES * LINES * PIXELS * arcade_pkg::CE_PIX_DIV + 16;
	localparam int AUDIO_CYCLES   = 6 * (1024 + 12);
	localparam int TEST_CYCLES    = IDLE_CYCLES + MAP_CYCLES + COLOUR_CYCLES +
	                                RASTER_CYCLES + AUDIO_CYCLES;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

	logic                           clk_sys;
	logic                           rst_n;
	logic [9:0]                     kb_joy;
	logic [7:0]                     joy0;
	logic [7:0]                     joy1;
	logic                           upright;
	logic [1:0]                     scan_mode;
	logic [2:0]                     core_r;
	logic [2:0]                     core_g;
	logic [1:0]                     core_b;
	logic                           core_hs;
	logic                           core_vs;
	logic                           core_hblank;
	logic                           core_vblank;
	logic [arcade_pkg::AUDIO_W-1:0] core_audio;
	logic                           ce_pix;
	logic                           ce_snd;
	logic [7:0]                     in0;
	logic [7:0]                     in1;
	logic [5:0]                     vga_r;
	logic [5:0]                     vga_g;
	logic [5:0]                     vga_b;
	logic                           vga_hs;
	logic                           vga_vs;
	logic                           audio_l;
	logic                           audio_r;

	arcade_shell u_arcade_shell (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.kb_joy      (kb_joy),
		.joy0        (joy0),
		.joy1        (joy1),
		.upright     (upright),
		.scan_mode   (scan_mode),
		.core_r      (core_r),
		.core_g      (core_g),
		.core_b      (core_b),
		.core_hs     (core_hs),
		.core_vs     (core_vs),
		.core_hblank (core_hblank),
		.core_vblank (core_vblank),
		.core_audio  (core_audio),
		.ce_pix      (ce_pix),
		.ce_snd      (ce_snd),
		.in0         (in0),
		.in1         (in1),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	always #4 clk_sys = ~clk_sys;

	// ============================================================
	// Failure reporting and random numbers
	// ============================================================

	task automatic stop_with_failure;
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_value_error(input string name, input logic [31:0] got,
	                                  input logic [31:0] want);
		$display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
		stop_with_failure();
	endtask

	logic [31:0] lfsr_state;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h80200003;
		end
		return next;
	endfunction

	function automatic logic [31:0] next_bits(input int count);
		logic [31:0] value;
		int          i;
		value = '0;
		for (i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// ============================================================
	// Reference models
	// ============================================================

	// Returns {in1, in0} for one setting of the player inputs
	function automatic logic [15:0] expect_inputs(input logic [9:0] kb, input logic [7:0] j0,
	                                              input logic [7:0] j1, input logic up);
		logic [7:0] sticks;
		logic       dir_u, dir_d, dir_l, dir_r;
		logic       out_u, out_d, out_l, out_r;
		logic [7:0] pressed0, pressed1;
		sticks = j0 | j1;
		dir_u = sticks[arcade_pkg::JOY_UP] | kb[arcade_pkg::KB_UP];
		dir_d = sticks[arcade_pkg::JOY_DOWN] | kb[arcade_pkg::KB_DOWN];
		dir_l = sticks[arcade_pkg::JOY_LEFT] | kb[arcade_pkg::KB_LEFT];
		dir_r = sticks[arcade_pkg::JOY_RIGHT] | kb[arcade_pkg::KB_RIGHT];
		// The upright cabinet takes up from left, down from right, left from down and right from up
		out_u = up ? dir_l : dir_u;
		out_d = up ? dir_r : dir_d;
		out_l = up ? dir_d : dir_l;
		out_r = up ? dir_u : dir_r;
		pressed0 = '0;
		pressed0[0] = out_u;
		pressed0[1] = out_l;
		pressed0[2] = out_r;
		pressed0[3] = out_d;
		pressed0[4] = sticks[arcade_pkg::JOY_FIRE] | kb[arcade_pkg::KB_FIRE];
		pressed0[5] = kb[arcade_pkg::KB_COIN];
		pressed1 = '0;
		pressed1[5] = kb[arcade_pkg::KB_START1];
		pressed1[6] = kb[arcade_pkg::KB_START2];
		return {~pressed1, ~pressed0};
	endfunction

	function automatic logic [5:0] scale_level(input logic [5:0] level, input logic [1:0] mode,
	                                           input logic odd);
		logic [5:0] result;
		result = level;
		if (odd && mode == arcade_pkg::SCAN_DIM25) begin
			result = level - level / 6'd4;
		end
		if (odd && mode == arcade_pkg::SCAN_DIM50) begin
			result = level / 6'd2;
		end
		return result;
	endfunction

	function automatic logic [17:0] expect_colour(input logic [2:0] r, input logic [2:0] g,
	                                              input logic [1:0] b, input logic blank,
	                                              input logic [1:0] mode, input logic odd);
		logic [17:0] rgb;
		rgb = '0;
		if (!blank) begin
			rgb = {scale_level({r, r}, mode, odd), scale_level({g, g}, mode, odd),
			       scale_level({b, b, b}, mode, odd)};
		end
		return rgb;
	endfunction

	int          run_cycles;
	int          cycle_count;
	logic [15:0] map_d1, map_d2, map_d3;
	logic [19:0] exp_vid;
	logic        ref_odd;
	logic        ref_hs_prev;
	logic        win_done;
	int          win_ones;
	int          win_expect;
	logic        exp_ce_pix;
	logic        exp_ce_snd;

	// The enables follow from the count of cycles since reset released
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			run_cycles <= 0;
		end else begin
			run_cycles <= run_cycles + 1;
		end
	end

	assign exp_ce_pix = (run_cycles != 0) && (run_cycles % arcade_pkg::CE_PIX_DIV == 0);
	assign exp_ce_snd = (run_cycles != 0) && (run_cycles % arcade_pkg::CE_SND_DIV == 0);

	// Mapped bytes appear three cycles after the inputs change
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			map_d1 <= 16'hffff;
			map_d2 <= 16'hffff;
			map_d3 <= 16'hffff;
		end else begin
			map_d1 <= expect_inputs(kb_joy, joy0, joy1, upright);
			map_d2 <= map_d1;
			map_d3 <= map_d2;
		end
	end

	// The video reference advances only on pixel enables
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			exp_vid     <= '0;
			ref_odd     <= 1'b0;
			ref_hs_prev <= 1'b0;
		end else if (ce_pix) begin
			exp_vid <= {expect_colour(core_r, core_g, core_b, core_hblank | core_vblank,
			                          scan_mode, ref_odd), core_hs, core_vs};
			ref_hs_prev <= core_hs;
			if (core_vs) begin
				ref_odd <= 1'b0;
			end else if (core_hs && !ref_hs_prev) begin
				ref_odd <= ~ref_odd;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	assert property (@(posedge clk_sys) disable iff (!rst_n) ce_pix == exp_ce_pix)
		else report_value_error("ce_pix", 32'($sampled(ce_pix)), 32'($sampled(exp_ce_pix)));

	assert property (@(posedge clk_sys) disable iff (!rst_n) ce_snd == exp_ce_snd)
		else report_value_error("ce_snd", 32'($sampled(ce_snd)), 32'($sampled(exp_ce_snd)));

	assert property (@(posedge clk_sys) disable iff (!rst_n) in0 == map_d3[7:0])
		else report_value_error("in0", 32'($sampled(in0)), 32'($sampled(map_d3[7:0])));

	assert property (@(posedge clk_sys) disable iff (!rst_n) in1 == map_d3[15:8])
		else report_value_error("in1", 32'($sampled(in1)), 32'($sampled(map_d3[15:8])));

	assert property (@(posedge clk_sys) disable iff (!rst_n)
		{vga_r, vga_g, vga_b} == exp_vid[19:2])
		else report_value_error("vga_rgb", 32'($sampled({vga_r, vga_g, vga_b})),
		                        32'($sampled(exp_vid[19:2])));

	assert property (@(posedge clk_sys) disable iff (!rst_n)
		{vga_hs, vga_vs} == exp_vid[1:0])
		else report_value_error("vga_hs_vs", 32'($sampled({vga_hs, vga_vs})),
		                        32'($sampled(exp_vid[1:0])));

	assert property (@(posedge clk_sys) disable iff (!rst_n) audio_r == audio_l)
		else report_value_error("audio_r", 32'($sampled(audio_r)), 32'($sampled(audio_l)));

	assert property (@(posedge clk_sys) disable iff (!rst_n) win_done |-> win_ones == win_expect)
		else report_value_error("audio_l ones", 32'($sampled(win_ones)),
		                        32'($sampled(win_expect)));

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic wait_pixel_enable;
		@(posedge clk_sys);
		while (!ce_pix) begin
			@(posedge clk_sys);
		end
	endtask

	task automatic map_random_inputs;
		int i;
		int hold;
		for (i = 0; i < MAP_SETTINGS; i++) begin
			// Sparse presses so single directions show up too
			kb_joy  <= 10'(next_bits(10) & next_bits(10));
			joy0    <= 8'(next_bits(8) & next_bits(8));
			joy1    <= 8'(next_bits(8) & next_bits(8));
			upright <= i[0];
			hold = 4 + int'(next_bits(2));
			repeat (hold) @(posedge clk_sys);
		end
	endtask

	task automatic drive_random_colour;
		scan_mode <= arcade_pkg::SCAN_NONE;
		repeat (COLOUR_CYCLES) begin
			core_r      <= 3'(next_bits(3));
			core_g      <= 3'(next_bits(3));
			core_b      <= 2'(next_bits(2));
			core_hblank <= next_bits(3) == 0;
			core_vblank <= next_bits(3) == 0;
			core_hs     <= next_bits(2) == 0;
			core_vs     <= next_bits(3) == 0;
			@(posedge clk_sys);
		end
	endtask

	// Syncs sit inside horizontal blanking and vsync marks the first line of a frame
	task automatic draw_raster(input logic [1:0] mode);
		int frame;
		int line;
		int px;
		scan_mode <= mode;
		for (frame = 0; frame < FRAMES; frame++) begin
			for (line = 0; line < LINES; line++) begin
				for (px = 0; px < PIXELS; px++) begin
					wait_pixel_enable();
					core_r      <= 3'(next_bits(3));
					core_g      <= 3'(next_bits(3));
					core_b      <= 2'(next_bits(2));
					core_hblank <= px < 2;
					core_vblank <= 1'b0;
					core_hs     <= px < 2;
					core_vs     <= (line == 0) && (px < 2);
				end
			end
		end
		wait_pixel_enable();
	endtask

	task automatic measure_audio(input logic [arcade_pkg::AUDIO_W-1:0] value);
		int ones;
		ones = 0;
		core_audio <= value;
		repeat (8) @(posedge clk_sys);
		repeat (1024) begin
			@(posedge clk_sys);
			if (audio_l) begin
				ones++;
			end
		end
		win_ones   <= ones;
		win_expect <= int'(value);
		win_done   <= 1'b1;
		@(posedge clk_sys);
		win_done <= 1'b0;
	endtask

	initial begin
		clk_sys     = 1'b0;
		rst_n       = 1'b0;
		kb_joy      = '0;
		joy0        = '0;
		joy1        = '0;
		upright     = 1'b0;
		scan_mode   = arcade_pkg::SCAN_NONE;
		core_r      = '0;
		core_g      = '0;
		core_b      = '0;
		core_hs     = 1'b0;
		core_vs     = 1'b0;
		core_hblank = 1'b0;
		core_vblank = 1'b0;
		core_audio  = '0;
		cycle_count = 0;
		win_done    = 1'b0;
		win_ones    = 0;
		win_expect  = 0;
		lfsr_state  = 32'h90780d89;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		// The idle gap covers the first enable periods after reset
		repeat (IDLE_CYCLES) @(posedge clk_sys);
		map_random_inputs();
		drive_random_colour();
		draw_raster(arcade_pkg::SCAN_DIM25);
		draw_raster(arcade_pkg::SCAN_DIM50);
		measure_audio(10'd0);
		measure_audio(10'd1);
		measure_audio(10'd511);
		measure_audio(10'd1023);
		measure_audio(10'(next_bits(10)));
		measure_audio(10'(next_bits(10)));
		repeat (4) @(posedge clk_sys);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== sim.f ====
arcade_pkg.sv
clock_enables.sv
control_mapper.sv
video_out.sv
sigma_delta_dac.sv
arcade_shell.sv
tb_arcade_shell.sv

// ==== Makefile ====
# Verilator flow for the arcade shell testbench

TOP = tb_arcade_shell

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP)

# Build and run, pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "SIMULATION PASSED" sim.log; then \
		echo "Run passed"; \
	else \
		echo "Run did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
